// ==== verilog/mem_defines.svh ====
// Width constants shared by the data memory unit RTL.
// Include this wherever a port or register is sized from these values.

`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ---------------------------------------------------------------------------
// address and data widths
// ---------------------------------------------------------------------------
`define MEM_ADDR_W      32      // byte address
`define MEM_WORD_W      32      // avalon data bus
`define MEM_WADDR_W     30      // avalon word address
`define MEM_RDATA_W     64      // read_data, up to 8 bytes

// ---------------------------------------------------------------------------
// lengths and bursts
// ---------------------------------------------------------------------------
`define MEM_RLEN_W      4       // read_length, 1 to 8 bytes
`define MEM_WLEN_W      3       // write_length, 1 to 4 bytes
`define MEM_BURST_W     4       // avm_burstcount

// an 8-byte read at offset 3 touches three words
`define MEM_RBEATS_MAX  3

`endif

// ==== verilog/mem_pkg.sv ====
// Types and small helpers for the data memory unit.
// Import with a wildcard inside the module body.

`include "mem_defines.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,   // waiting for a link request
        ARB_WRITE = 2'd1,   // write burst on avalon
        ARB_READ  = 2'd2    // read command and data beats
    } arb_state_t;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    // number of words touched by a read, 1 to 3
    function automatic logic [`MEM_BURST_W-1:0] read_words(
        input logic [1:0]             offset,
        input logic [`MEM_RLEN_W-1:0] length
    );
        logic [`MEM_RLEN_W:0] last_byte;
        last_byte = {3'b000, offset} + {1'b0, length} - 1'b1;   // byte index of last byte
        return `MEM_BURST_W'(last_byte[`MEM_RLEN_W:2]) + 1'b1;
    endfunction

    // byte lanes over two words for a 1 to 4 byte write
    function automatic logic [7:0] lane_mask(
        input logic [1:0]             offset,
        input logic [`MEM_WLEN_W-1:0] length
    );
        logic [7:0] base;
        base = (8'd1 << length) - 8'd1;     // length ones at lane 0
        return base << offset;
    endfunction

endpackage

// ==== verilog/mem_link_if.sv ====
// Internal links between the port modules and the Avalon arbiter.
// The master side raises burst_do and holds its fields until burst_done.

`timescale 1ns/1ps

`include "mem_defines.svh"

// ---------------------------------------------------------------------------
// read link
// ---------------------------------------------------------------------------
interface mem_rd_link_if;
    logic                                       burst_do;   // level, held until done
    logic                                       burst_done; // one-cycle pulse
    logic [`MEM_WADDR_W-1:0]                    waddr;      // first word
    logic [`MEM_BURST_W-1:0]                    burstcount; // 1 to 3
    logic [`MEM_RBEATS_MAX*`MEM_WORD_W-1:0]     rdata;      // words packed low first

    modport master (
        output burst_do, waddr, burstcount,
        input  burst_done, rdata
    );
    modport slave (
        input  burst_do, waddr, burstcount,
        output burst_done, rdata
    );
endinterface

// ---------------------------------------------------------------------------
// write link
// ---------------------------------------------------------------------------
interface mem_wr_link_if;
    logic                           burst_do;
    logic                           burst_done;
    logic [`MEM_WADDR_W-1:0]        waddr;
    logic [`MEM_BURST_W-1:0]        burstcount; // 1 or 2
    logic [`MEM_WORD_W/8-1:0]       be_first;   // lanes of beat 0
    logic [`MEM_WORD_W/8-1:0]       be_last;    // lanes of beat 1
    logic [2*`MEM_WORD_W-1:0]       wdata;      // beat 1 word in the high half

    modport master (
        output burst_do, waddr, burstcount, be_first, be_last, wdata,
        input  burst_done
    );
    modport slave (
        input  burst_do, waddr, burstcount, be_first, be_last, wdata,
        output burst_done
    );
endinterface

// ==== verilog/memory_read.sv ====
// Data read port of the memory unit.
// Takes a 1 to 8 byte read at any byte address, fetches the words it
// touches over the read link and returns the bytes aligned to bit 0.

`timescale 1ns/1ps

`include "mem_defines.svh"

module memory_read (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        read_do,
    output logic                        read_done,
    input  logic [`MEM_ADDR_W-1:0]      read_address,
    input  logic [`MEM_RLEN_W-1:0]      read_length,
    output logic [`MEM_RDATA_W-1:0]     read_data,

    mem_rd_link_if.master               link
);
    import mem_pkg::*;

    logic [`MEM_ADDR_W-1:0]                     addr_q;     // held byte address
    logic [`MEM_RLEN_W-1:0]                     len_q;      // held byte count
    logic [1:0]                                 offset;     // byte within first word
    logic                                       accept;
    logic [`MEM_RBEATS_MAX*`MEM_WORD_W-1:0]     aligned;

    // -----------------------------------------------------------------------
    // request side
    // -----------------------------------------------------------------------

    // idle, and not the done cycle where the old request is still on read_do
    assign accept = read_do && !link.burst_do && !read_done;

    assign offset          = addr_q[1:0];
    assign link.waddr      = addr_q[`MEM_ADDR_W-1:2];   // word of the first byte
    assign link.burstcount = read_words(offset, len_q); // 1..3 words

    always_ff @(posedge clk) begin
        if (rst) begin
            link.burst_do <= 1'b0;
            read_done     <= 1'b0;
        end else begin
            read_done <= link.burst_done;       // one cycle after link done
            if (link.burst_done) begin
                link.burst_do <= 1'b0;          // falls right after done
            end else if (accept) begin
                link.burst_do <= 1'b1;
            end
        end
    end

    // -----------------------------------------------------------------------
    // data side
    // -----------------------------------------------------------------------

    // first requested byte down to lane 0
    assign aligned = link.rdata >> {offset, 3'b000};

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= read_address;
            len_q  <= read_length;
        end
        if (link.burst_done) begin
            read_data <= aligned[`MEM_RDATA_W-1:0];     // valid with read_done
        end
    end

endmodule

// ==== verilog/memory_write.sv ====
// Data write port of the memory unit.
// Takes a 1 to 4 byte write at any byte address and hands the arbiter one
// or two beats with the byte enables and data moved into their lanes.

`timescale 1ns/1ps

`include "mem_defines.svh"

module memory_write (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        write_do,
    output logic                        write_done,
    input  logic [`MEM_ADDR_W-1:0]      write_address,
    input  logic [`MEM_WLEN_W-1:0]      write_length,
    input  logic [`MEM_WORD_W-1:0]      write_data,

    mem_wr_link_if.master               link
);
    import mem_pkg::*;

    logic [`MEM_ADDR_W-1:0]     addr_q;
    logic [`MEM_WLEN_W-1:0]     len_q;
    logic [`MEM_WORD_W-1:0]     data_q;
    logic [1:0]                 offset;
    logic                       accept;
    logic [7:0]                 mask;       // lanes over the two words

    // -----------------------------------------------------------------------
    // request control
    // -----------------------------------------------------------------------

    // new request only once the previous done has gone by
    assign accept = write_do && !link.burst_do && !write_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            link.burst_do <= 1'b0;
            write_done    <= 1'b0;
        end else begin
            write_done <= link.burst_done;
            if (link.burst_done) begin
                link.burst_do <= 1'b0;
            end else if (accept) begin
                link.burst_do <= 1'b1;      // one cycle after write_do
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= write_address;
            len_q  <= write_length;
            data_q <= write_data;
        end
    end

    // -----------------------------------------------------------------------
    // lane placement
    // -----------------------------------------------------------------------
    assign offset = addr_q[1:0];
    assign mask   = lane_mask(offset, len_q);

    assign link.waddr    = addr_q[`MEM_ADDR_W-1:2];
    assign link.be_first = mask[3:0];
    assign link.be_last  = mask[7:4];

    // second beat only when bytes spill into the next word
    assign link.burstcount = (mask[7:4] != 4'b0000) ? `MEM_BURST_W'(2) : `MEM_BURST_W'(1);

    assign link.wdata = {{`MEM_WORD_W{1'b0}}, data_q} << {offset, 3'b000};

endmodule

// ==== verilog/avalon_mem.sv ====
// Avalon master of the memory unit.
// Grants the write link before the read link and runs one burst per grant;
// the granted link gets a done pulse once its last beat has gone by.

`timescale 1ns/1ps

`include "mem_defines.svh"

module avalon_mem (
    input  logic                        clk,
    input  logic                        rst,

    mem_rd_link_if.slave                rd,
    mem_wr_link_if.slave                wr,

    // avalon master
    output logic [`MEM_WADDR_W-1:0]     avm_address,
    output logic [`MEM_WORD_W-1:0]      avm_writedata,
    output logic [`MEM_WORD_W/8-1:0]    avm_byteenable,
    output logic [`MEM_BURST_W-1:0]     avm_burstcount,
    output logic                        avm_write,
    output logic                        avm_read,
    input  logic                        avm_waitrequest,
    input  logic                        avm_readdatavalid,
    input  logic [`MEM_WORD_W-1:0]      avm_readdata
);
    import mem_pkg::*;

    arb_state_t                                 state;
    req_kind_t                                  kind;       // link owning the bus
    logic                                       done_q;
    logic [`MEM_BURST_W-1:0]                    beat;       // beats finished so far
    logic                                       last_beat;
    logic                                       grant_wr;
    logic                                       grant_rd;
    logic [`MEM_RBEATS_MAX*`MEM_WORD_W-1:0]     collect;    // read words, low first

    // -----------------------------------------------------------------------
    // arbitration
    // -----------------------------------------------------------------------

    // a link still high in its own done cycle is the finished request
    assign grant_wr = (state == ARB_IDLE) && wr.burst_do && !wr.burst_done;
    assign grant_rd = (state == ARB_IDLE) && !grant_wr && rd.burst_do && !rd.burst_done;

    assign last_beat = (beat == avm_burstcount - 1'b1);

    assign wr.burst_done = done_q && (kind == REQ_WRITE);
    assign rd.burst_done = done_q && (kind == REQ_READ);
    assign rd.rdata      = collect;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ARB_IDLE;
            kind      <= REQ_READ;
            done_q    <= 1'b0;
            beat      <= '0;
            avm_write <= 1'b0;
            avm_read  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    beat <= '0;
                    if (grant_wr) begin
                        state     <= ARB_WRITE;
                        kind      <= REQ_WRITE;
                        avm_write <= 1'b1;      // burst starts next cycle
                    end else if (grant_rd) begin
                        state    <= ARB_READ;
                        kind     <= REQ_READ;
                        avm_read <= 1'b1;
                    end
                end
                ARB_WRITE: begin
                    if (!avm_waitrequest) begin     // beat taken
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            avm_write <= 1'b0;
                            done_q    <= 1'b1;
                            state     <= ARB_IDLE;
                        end
                    end
                end
                ARB_READ: begin
                    if (avm_read && !avm_waitrequest) begin
                        avm_read <= 1'b0;           // command accepted
                    end
                    if (avm_readdatavalid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            done_q <= 1'b1;
                            state  <= ARB_IDLE;
                        end
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // command and data registers
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (grant_wr) begin
            avm_address    <= wr.waddr;
            avm_burstcount <= wr.burstcount;
            avm_writedata  <= wr.wdata[`MEM_WORD_W-1:0];
            avm_byteenable <= wr.be_first;
        end else if (grant_rd) begin
            avm_address    <= rd.waddr;
            avm_burstcount <= rd.burstcount;
            avm_byteenable <= '1;                   // whole words on reads
        end else if (state == ARB_WRITE && !avm_waitrequest) begin
            avm_writedata  <= wr.wdata[2*`MEM_WORD_W-1:`MEM_WORD_W];  // second beat
            avm_byteenable <= wr.be_last;
        end

        if (state == ARB_READ && avm_readdatavalid) begin
            collect[beat*`MEM_WORD_W +: `MEM_WORD_W] <= avm_readdata;
        end
    end

endmodule

// ==== verilog/memory.sv ====
// Top level of the data memory unit.
// Read and write ports share one Avalon master, writes first.

`timescale 1ns/1ps

`include "mem_defines.svh"

module memory (
    input  logic                        clk,
    input  logic                        rst,

    // read port
    input  logic                        read_do,
    output logic                        read_done,
    input  logic [`MEM_ADDR_W-1:0]      read_address,
    input  logic [`MEM_RLEN_W-1:0]      read_length,
    output logic [`MEM_RDATA_W-1:0]     read_data,

    // write port
    input  logic                        write_do,
    output logic                        write_done,
    input  logic [`MEM_ADDR_W-1:0]      write_address,
    input  logic [`MEM_WLEN_W-1:0]      write_length,
    input  logic [`MEM_WORD_W-1:0]      write_data,

    // avalon master
    output logic [`MEM_WADDR_W-1:0]     avm_address,
    output logic [`MEM_WORD_W-1:0]      avm_writedata,
    output logic [`MEM_WORD_W/8-1:0]    avm_byteenable,
    output logic [`MEM_BURST_W-1:0]     avm_burstcount,
    output logic                        avm_write,
    output logic                        avm_read,
    input  logic                        avm_waitrequest,
    input  logic                        avm_readdatavalid,
    input  logic [`MEM_WORD_W-1:0]      avm_readdata
);

    mem_rd_link_if rd_link ();
    mem_wr_link_if wr_link ();

    //--------------------------------------------------------------------------

    memory_read memory_read_inst (
        .clk            (clk),
        .rst            (rst),
        .read_do        (read_do),
        .read_done      (read_done),
        .read_address   (read_address),
        .read_length    (read_length),
        .read_data      (read_data),
        .link           (rd_link.master)
    );

    memory_write memory_write_inst (
        .clk            (clk),
        .rst            (rst),
        .write_do       (write_do),
        .write_done     (write_done),
        .write_address  (write_address),
        .write_length   (write_length),
        .write_data     (write_data),
        .link           (wr_link.master)
    );

    //--------------------------------------------------------------------------

    avalon_mem avalon_mem_inst (
        .clk                (clk),
        .rst                (rst),
        .rd                 (rd_link.slave),
        .wr                 (wr_link.slave),
        .avm_address        (avm_address),
        .avm_writedata      (avm_writedata),
        .avm_byteenable     (avm_byteenable),
        .avm_burstcount     (avm_burstcount),
        .avm_write          (avm_write),
        .avm_read           (avm_read),
        .avm_waitrequest    (avm_waitrequest),
        .avm_readdatavalid  (avm_readdatavalid),
        .avm_readdata       (avm_readdata)
    );

endmodule

// ==== tb/memory_props.sv ====
// Concurrent checks on the Avalon master and the done pulses of the memory unit.
// Bound into every memory instance at the end of this file.

`timescale 1ns/1ps

`include "mem_defines.svh"

module memory_props (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        avm_read,
    input  logic                        avm_write,
    input  logic                        avm_waitrequest,
    input  logic [`MEM_WADDR_W-1:0]     avm_address,
    input  logic [`MEM_WORD_W-1:0]      avm_writedata,
    input  logic [`MEM_WORD_W/8-1:0]    avm_byteenable,
    input  logic [`MEM_BURST_W-1:0]     avm_burstcount,
    input  logic                        read_done,
    input  logic                        write_done
);

    int fails = 0;      // failed assertions so far

    // -----------------------------------------------------------------------
    // avalon command rules
    // -----------------------------------------------------------------------
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(avm_read && avm_write))
    else begin
        $error("avm_read and avm_write high together");
        fails++;
    end

    rd_cmd_held: assert property (@(posedge clk) disable iff (rst)
        avm_read && avm_waitrequest |=>
            avm_read && $stable(avm_address) && $stable(avm_burstcount))
    else begin
        $error("read command changed under waitrequest");
        fails++;
    end

    wr_beat_held: assert property (@(posedge clk) disable iff (rst)
        avm_write && avm_waitrequest |=>
            avm_write && $stable(avm_address) && $stable(avm_burstcount)
            && $stable(avm_writedata) && $stable(avm_byteenable))
    else begin
        $error("write beat changed under waitrequest");
        fails++;
    end

    rd_burst_range: assert property (@(posedge clk) disable iff (rst)
        avm_read |-> (avm_burstcount >= 1 && avm_burstcount <= 3))
    else begin
        $error("read burstcount out of range");
        fails++;
    end

    wr_burst_range: assert property (@(posedge clk) disable iff (rst)
        avm_write |-> (avm_burstcount == 1 || avm_burstcount == 2))
    else begin
        $error("write burstcount out of range");
        fails++;
    end

    // -----------------------------------------------------------------------
    // done pulses
    // -----------------------------------------------------------------------
    rd_done_pulse: assert property (@(posedge clk) disable iff (rst)
        read_done |=> !read_done)
    else begin
        $error("read_done high for more than one cycle");
        fails++;
    end

    wr_done_pulse: assert property (@(posedge clk) disable iff (rst)
        write_done |=> !write_done)
    else begin
        $error("write_done high for more than one cycle");
        fails++;
    end

endmodule

bind memory memory_props memory_props_i (
    .clk                (clk),
    .rst                (rst),
    .avm_read           (avm_read),
    .avm_write          (avm_write),
    .avm_waitrequest    (avm_waitrequest),
    .avm_address        (avm_address),
    .avm_writedata      (avm_writedata),
    .avm_byteenable     (avm_byteenable),
    .avm_burstcount     (avm_burstcount),
    .read_done          (read_done),
    .write_done         (write_done)
);

// ==== tb/memory_tb.sv ====
// Testbench for the data memory unit.
// Runs the operations of tb/memory_input.txt against a word-memory Avalon slave
// with random waitrequest and readdatavalid gaps; checks data, lanes and order.

`timescale 1ns/1ps

`include "mem_defines.svh"

module memory_tb;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 200;     // cycles allowed per wait

    logic                       clk;
    logic                       rst;
    logic                       read_do;
    logic                       read_done;
    logic [`MEM_ADDR_W-1:0]     read_address;
    logic [`MEM_RLEN_W-1:0]     read_length;
    logic [`MEM_RDATA_W-1:0]    read_data;
    logic                       write_do;
    logic                       write_done;
    logic [`MEM_ADDR_W-1:0]     write_address;
    logic [`MEM_WLEN_W-1:0]     write_length;
    logic [`MEM_WORD_W-1:0]     write_data;
    logic [`MEM_WADDR_W-1:0]    avm_address;
    logic [`MEM_WORD_W-1:0]     avm_writedata;
    logic [`MEM_WORD_W/8-1:0]   avm_byteenable;
    logic [`MEM_BURST_W-1:0]    avm_burstcount;
    logic                       avm_write;
    logic                       avm_read;
    logic                       avm_waitrequest   = 1'b0;
    logic                       avm_readdatavalid = 1'b0;
    logic [`MEM_WORD_W-1:0]     avm_readdata      = '0;

    logic [31:0]    mem [0:MEM_WORDS-1];        // slave storage
    logic [7:0]     shadow [0:4*MEM_WORDS-1];   // expected bytes
    logic [7:0]     wr_word;                    // first word of the write burst
    logic [7:0]     rd_word;                    // next word to return
    int             wr_beat;
    int             rd_left;                    // read words still owed
    int             rd_burst;                   // burstcount of the last read command
    bit             burst_log [$];              // 1 write, 0 read, command order
    logic [3:0]     be_log [$];                 // byte enables per write beat

    int             checks;
    int             mismatches;
    int             run_errors;
    bit             timed_out;

    memory memory_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // -----------------------------------------------------------------------
    // avalon slave model
    // -----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] = '0;
            end
            wr_beat  = 0;
            rd_left  = 0;
            rd_burst = 0;
            avm_waitrequest   <= 1'b0;
            avm_readdatavalid <= 1'b0;
        end else begin
            if (avm_write && !avm_waitrequest) begin            // beat taken
                if (wr_beat == 0) begin
                    wr_word = avm_address[7:0];
                    burst_log.push_back(1'b1);
                end
                for (int lane = 0; lane < 4; lane++) begin
                    if (avm_byteenable[lane]) begin
                        mem[wr_word + 8'(wr_beat)][8*lane +: 8] = avm_writedata[8*lane +: 8];
                    end
                end
                be_log.push_back(avm_byteenable);
                wr_beat = wr_beat + 1;
                if (wr_beat == avm_burstcount) wr_beat = 0;
            end
            if (avm_read && !avm_waitrequest) begin             // command taken
                rd_word  = avm_address[7:0];
                rd_left  = avm_burstcount;
                rd_burst = avm_burstcount;
                burst_log.push_back(1'b0);
            end
            avm_readdatavalid <= 1'b0;
            if (rd_left != 0 && ($urandom % 3) != 0) begin      // gaps of random length
                avm_readdatavalid <= 1'b1;
                avm_readdata      <= mem[rd_word];
                rd_word = rd_word + 8'd1;
                rd_left = rd_left - 1;
            end
            avm_waitrequest <= (($urandom % 3) == 0);
        end
    end

    // -----------------------------------------------------------------------
    // checks
    // -----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_memory();
        for (int w = 0; w < MEM_WORDS; w++) begin
            check_value($sformatf("mem[%0d]", w), mem[w],
                        {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]});
        end
    endtask

    // one lane per written byte, counted from the byte offset
    task automatic check_write(input logic [31:0] addr, input int len);
        logic [7:0] lanes;
        lanes = 8'h00;
        for (int i = 0; i < len; i++) begin
            lanes[addr[1:0] + i] = 1'b1;
        end
        check_value("write beats", be_log.size(), (lanes[7:4] != 4'd0) ? 2 : 1);
        if (be_log.size() > 0) check_value("avm_byteenable beat 0", be_log[0], lanes[3:0]);
        if (be_log.size() > 1) check_value("avm_byteenable beat 1", be_log[1], lanes[7:4]);
        compare_memory();
    endtask

    task automatic check_read(input logic [31:0] addr, input int len, input logic [63:0] got,
                              input logic [63:0] exp);
        logic [63:0] keep;
        int          words;
        keep  = (len >= 8) ? {64{1'b1}} : (64'd1 << (8 * len)) - 64'd1;
        words = (addr[1:0] + len + 3) / 4;      // words holding the requested bytes
        check_value("read burst words", rd_burst, words);
        check_value("read_data", got & keep, exp & keep);
    endtask

    // -----------------------------------------------------------------------
    // stimulus
    // -----------------------------------------------------------------------
    task automatic start_write(input logic [31:0] addr, input int len, input logic [31:0] data);
        write_do      <= 1'b1;
        write_address <= addr;
        write_length  <= `MEM_WLEN_W'(len);
        write_data    <= data;
        be_log.delete();
        for (int i = 0; i < len; i++) begin
            shadow[10'(addr + i)] = data[8*i +: 8];     // little endian from addr
        end
    endtask

    task automatic start_read(input logic [31:0] addr, input int len);
        read_do      <= 1'b1;
        read_address <= addr;
        read_length  <= `MEM_RLEN_W'(len);
    endtask

    // sample at the falling edge, drop do on the rising edge after done
    task automatic wait_dones(input bit need_wr, input bit need_rd, output logic [63:0] got);
        bit wr_seen;
        bit rd_seen;
        int cycles;
        wr_seen = !need_wr;
        rd_seen = !need_rd;
        cycles  = 0;
        got     = '0;
        while (!(wr_seen && rd_seen) && cycles < TIMEOUT) begin
            @(negedge clk);
            if (need_wr && write_done) wr_seen = 1'b1;
            if (need_rd && read_done) begin
                rd_seen = 1'b1;
                got     = read_data;
            end
            @(posedge clk);
            if (need_wr && wr_seen) write_do <= 1'b0;
            if (need_rd && rd_seen) read_do <= 1'b0;
            cycles++;
        end
        if (!(wr_seen && rd_seen)) begin
            $display("timeout: %s did not arrive within %0d cycles",
                     wr_seen ? "read_done" : "write_done", TIMEOUT);
            run_errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int             fd;
        int             code;
        string          op;
        string          rest;
        logic [31:0]    w_addr;
        logic [31:0]    w_data;
        logic [31:0]    r_addr;
        int             w_len;
        int             r_len;
        logic [63:0]    r_exp;
        logic [63:0]    got;

        code = $urandom(32'h4ac6_6560);
        rst           = 1'b1;
        read_do       = 1'b0;
        read_address  = '0;
        read_length   = '0;
        write_do      = 1'b0;
        write_address = '0;
        write_length  = '0;
        write_data    = '0;
        checks        = 0;
        mismatches    = 0;
        run_errors    = 0;
        timed_out     = 1'b0;
        for (int i = 0; i < 4 * MEM_WORDS; i++) begin
            shadow[i] = 8'h00;
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin                        // quiet after reset
            @(negedge clk);
            check_value("avm_read,avm_write,read_done,write_done",
                        {avm_read, avm_write, read_done, write_done}, 4'b0000);
        end

        fd = $fopen("tb/memory_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file tb/memory_input.txt");
            run_errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);    // column notes
                end else if (op == "W") begin
                    code = $fscanf(fd, "%h %d %h", w_addr, w_len, w_data);
                    @(posedge clk);
                    start_write(w_addr, w_len, w_data);
                    wait_dones(1'b1, 1'b0, got);
                    check_write(w_addr, w_len);
                end else if (op == "R") begin
                    code = $fscanf(fd, "%h %d %h", r_addr, r_len, r_exp);
                    @(posedge clk);
                    start_read(r_addr, r_len);
                    wait_dones(1'b0, 1'b1, got);
                    check_read(r_addr, r_len, got, r_exp);
                end else if (op == "B") begin
                    code = $fscanf(fd, "%h %d %h %h %d %h",
                                   w_addr, w_len, w_data, r_addr, r_len, r_exp);
                    burst_log.delete();
                    @(posedge clk);
                    start_write(w_addr, w_len, w_data);     // both ports, same edge
                    start_read(r_addr, r_len);
                    wait_dones(1'b1, 1'b1, got);
                    check_value("bursts seen", burst_log.size(), 2);
                    if (burst_log.size() == 2) begin
                        check_value("burst order (write 1, read 0)",
                                    {burst_log[0], burst_log[1]}, 2'b10);
                    end
                    check_write(w_addr, w_len);
                    check_read(r_addr, r_len, got, r_exp);
                end else begin
                    $display("unknown operation %s in stimulus file", op);
                    run_errors++;
                end
            end
            $fclose(fd);
        end

        $display("checks %0d, mismatches %0d, run errors %0d, assertion failures %0d",
                 checks, mismatches, run_errors, memory_i.memory_props_i.fails);
        if (mismatches == 0 && run_errors == 0 && memory_i.memory_props_i.fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_link_if.sv
verilog/memory_read.sv
verilog/memory_write.sv
verilog/avalon_mem.sv
verilog/memory.sv
tb/memory_props.sv
tb/memory_tb.sv

// ==== tb/memory_input.txt ====
# W byte_addr length write_data | R byte_addr length expected_read_data
# B write fields then read fields, both ports started on the same edge
W 00000000 4 44332211
W 00000004 4 88776655
W 00000008 4 ccbbaa99
R 00000004 4 0000000088776655
R 00000001 4 0000000055443322
R 00000003 8 bbaa998877665544
R 00000002 7 0099887766554433
W 00000013 3 00c0ffee
R 00000012 5 00000000c0ffee00
W 0000001e 4 d4c3b2a1
R 0000001c 8 0000d4c3b2a10000
W 00000025 1 000000aa
W 00000027 2 00003412
R 00000024 6 000000341200aa00
R 00000025 1 00000000000000aa
B 00000042 2 00005a5b 00000040 4 000000005a5b0000
B 0000004f 4 0d0c0b0a 0000004d 8 00000d0c0b0a0000
R 00000000 8 8877665544332211
W 000003fe 2 00007788
R 000003fc 4 0000000077880000
R 0000000a 3 000000000000ccbb
